// ==== common/fir_pkg.sv ====
`default_nettype none

package fir_pkg;

    localparam int MAX_TAPS = 11;  // coefficient and history slots
    localparam int ADDR_W   = 12;
    localparam int DATA_W   = 32;

    typedef logic [ADDR_W-1:0]        axil_addr_t;
    typedef logic signed [DATA_W-1:0] sample_t;
    typedef logic signed [DATA_W-1:0] coef_t;
    typedef logic signed [63:0]       acc_t;
    typedef logic [3:0]               tap_idx_t;
    typedef logic [DATA_W-1:0]        len_t;

    // register map
    localparam axil_addr_t ADDR_AP_CTRL  = 12'h000;
    localparam axil_addr_t ADDR_DATA_LEN = 12'h010;
    localparam axil_addr_t ADDR_TAP_NUM  = 12'h014;
    localparam axil_addr_t ADDR_TAP_BASE = 12'h080;  // taps in steps of 4

    localparam int AP_START_BIT = 0;
    localparam int AP_DONE_BIT  = 1;
    localparam int AP_IDLE_BIT  = 2;

    localparam logic [DATA_W-1:0] TAP_READ_BUSY = '1;

    typedef struct packed {
        len_t     data_len;
        tap_idx_t tap_num;  // already clamped to 1..MAX_TAPS
    } fir_cfg_t;

    typedef struct packed {
        logic     en;
        tap_idx_t idx;
        coef_t    data;
    } tap_wr_t;

    typedef struct packed {
        logic en;
        logic first;  // restart accumulation
        logic last;   // final tap of this sample
        logic eos;    // final result of the run
    } mac_op_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_X,
        ST_MAC,
        ST_OUT
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== axil/fir_axil_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module fir_axil_slave (
    input  logic                         axis_clk_i,
    input  logic                         axis_rst_n_i,
    input  logic                         s_awvalid_i,
    output logic                         s_awready_o,
    input  fir_pkg::axil_addr_t          s_awaddr_i,
    input  logic                         s_wvalid_i,
    output logic                         s_wready_o,
    input  logic [fir_pkg::DATA_W-1:0]   s_wdata_i,
    output logic                         s_bvalid_o,
    input  logic                         s_bready_i,
    output logic [1:0]                   s_bresp_o,
    input  logic                         s_arvalid_i,
    output logic                         s_arready_o,
    input  fir_pkg::axil_addr_t          s_araddr_i,
    output logic                         s_rvalid_o,
    input  logic                         s_rready_i,
    output logic [fir_pkg::DATA_W-1:0]   s_rdata_o,
    output logic [1:0]                   s_rresp_o,
    output fir_pkg::fir_cfg_t            cfg_o,
    output logic                         ap_start_o,
    input  logic                         busy_i,
    input  logic                         run_done_i,
    output fir_pkg::tap_wr_t             tap_wr_o,
    output fir_pkg::tap_idx_t            tap_rd_idx_o,
    input  fir_pkg::coef_t               tap_rd_data_i
);

    logic                       awready_q, bvalid_q, arready_q, rvalid_q;
    logic                       done_q, idle_q, ap_start_q;
    fir_pkg::len_t              data_len_q;
    fir_pkg::tap_idx_t          tap_num_q, tap_num_new;
    logic [fir_pkg::DATA_W-1:0] rdata_q, rd_word;
    fir_pkg::axil_addr_t        aw_off, ar_off;
    logic                       wr_fire, rd_fire, cfg_wr_ok, start_req;
    logic                       aw_is_tap, ar_is_tap;

    assign wr_fire   = awready_q && s_awvalid_i && s_wvalid_i;
    assign rd_fire   = arready_q && s_arvalid_i;
    assign cfg_wr_ok = wr_fire && !busy_i;  // config frozen during a run
    assign start_req = cfg_wr_ok && idle_q && (s_awaddr_i == fir_pkg::ADDR_AP_CTRL)
                       && s_wdata_i[fir_pkg::AP_START_BIT];

    assign aw_off    = s_awaddr_i - fir_pkg::ADDR_TAP_BASE;
    assign ar_off    = s_araddr_i - fir_pkg::ADDR_TAP_BASE;
    assign aw_is_tap = (s_awaddr_i >= fir_pkg::ADDR_TAP_BASE)
                       && (aw_off[fir_pkg::ADDR_W-1:2] < fir_pkg::MAX_TAPS);
    assign ar_is_tap = (s_araddr_i >= fir_pkg::ADDR_TAP_BASE)
                       && (ar_off[fir_pkg::ADDR_W-1:2] < fir_pkg::MAX_TAPS);

    always_comb begin  // clamp tap count into 1..MAX_TAPS
        if (s_wdata_i == '0) begin
            tap_num_new = fir_pkg::tap_idx_t'(1);
        end else if (s_wdata_i > fir_pkg::MAX_TAPS) begin
            tap_num_new = fir_pkg::tap_idx_t'(fir_pkg::MAX_TAPS);
        end else begin
            tap_num_new = fir_pkg::tap_idx_t'(s_wdata_i);
        end
    end

    always_ff @(posedge axis_clk_i or negedge axis_rst_n_i) begin
        if (!axis_rst_n_i) begin
            awready_q  <= 1'b0;
            bvalid_q   <= 1'b0;
            arready_q  <= 1'b0;
            rvalid_q   <= 1'b0;
            ap_start_q <= 1'b0;
            done_q     <= 1'b0;
            idle_q     <= 1'b1;
            data_len_q <= '0;
            tap_num_q  <= fir_pkg::tap_idx_t'(1);
        end else begin
            awready_q <= s_awvalid_i && s_wvalid_i && !bvalid_q && !awready_q;
            if (wr_fire) begin
                bvalid_q <= 1'b1;
            end else if (s_bready_i) begin
                bvalid_q <= 1'b0;
            end
            arready_q <= s_arvalid_i && !rvalid_q && !arready_q;
            if (rd_fire) begin
                rvalid_q <= 1'b1;
            end else if (s_rready_i) begin
                rvalid_q <= 1'b0;
            end
            if (cfg_wr_ok && s_awaddr_i == fir_pkg::ADDR_DATA_LEN) begin
                data_len_q <= s_wdata_i;
            end
            if (cfg_wr_ok && s_awaddr_i == fir_pkg::ADDR_TAP_NUM) begin
                tap_num_q <= tap_num_new;
            end
            ap_start_q <= start_req;
            if (start_req) begin  // new run clears done and idle
                done_q <= 1'b0;
                idle_q <= 1'b0;
            end else if (run_done_i) begin
                done_q <= 1'b1;
                idle_q <= 1'b1;
            end
        end
    end

    always_comb begin
        rd_word = '0;
        if (s_araddr_i == fir_pkg::ADDR_AP_CTRL) begin
            rd_word[fir_pkg::AP_START_BIT] = ap_start_q;
            rd_word[fir_pkg::AP_DONE_BIT]  = done_q;
            rd_word[fir_pkg::AP_IDLE_BIT]  = idle_q;
        end else if (s_araddr_i == fir_pkg::ADDR_DATA_LEN) begin
            rd_word = data_len_q;
        end else if (s_araddr_i == fir_pkg::ADDR_TAP_NUM) begin
            rd_word[$bits(fir_pkg::tap_idx_t)-1:0] = tap_num_q;
        end else if (ar_is_tap) begin
            rd_word = busy_i ? fir_pkg::TAP_READ_BUSY : tap_rd_data_i;
        end
    end

    always_ff @(posedge axis_clk_i) begin
        if (rd_fire) begin
            rdata_q <= rd_word;
        end
    end

    assign s_awready_o = awready_q;
    assign s_wready_o  = awready_q;  // aw and w accepted together
    assign s_bvalid_o  = bvalid_q;
    assign s_bresp_o   = 2'b00;      // okay
    assign s_arready_o = arready_q;
    assign s_rvalid_o  = rvalid_q;
    assign s_rdata_o   = rdata_q;
    assign s_rresp_o   = 2'b00;

    assign cfg_o.data_len = data_len_q;
    assign cfg_o.tap_num  = tap_num_q;
    assign ap_start_o     = ap_start_q;

    assign tap_wr_o.en   = cfg_wr_ok && aw_is_tap;
    assign tap_wr_o.idx  = fir_pkg::tap_idx_t'(aw_off[fir_pkg::ADDR_W-1:2]);
    assign tap_wr_o.data = s_wdata_i;
    assign tap_rd_idx_o  = fir_pkg::tap_idx_t'(ar_off[fir_pkg::ADDR_W-1:2]);

endmodule

`default_nettype wire

// ==== logic/fir_tap_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module fir_tap_ram (
    input  logic              axis_clk_i,
    input  logic              axis_rst_n_i,
    input  fir_pkg::tap_wr_t  wr_i,
    input  fir_pkg::tap_idx_t rd_a_idx_i,
    input  fir_pkg::tap_idx_t rd_b_idx_i,
    output fir_pkg::coef_t    rd_a_data_o,
    output fir_pkg::coef_t    rd_b_data_o
);

    fir_pkg::coef_t taps_q [fir_pkg::MAX_TAPS];

    always_ff @(posedge axis_clk_i or negedge axis_rst_n_i) begin
        if (!axis_rst_n_i) begin
            for (int k = 0; k < fir_pkg::MAX_TAPS; k++) begin
                taps_q[k] <= '0;
            end
        end else if (wr_i.en && wr_i.idx < fir_pkg::MAX_TAPS) begin
            taps_q[wr_i.idx] <= wr_i.data;
        end
    end

    // host port a, engine port b
    assign rd_a_data_o = (rd_a_idx_i < fir_pkg::MAX_TAPS) ? taps_q[rd_a_idx_i] : '0;
    assign rd_b_data_o = (rd_b_idx_i < fir_pkg::MAX_TAPS) ? taps_q[rd_b_idx_i] : '0;

endmodule

`default_nettype wire

// ==== logic/fir_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fir_ctrl (
    input  logic              axis_clk_i,
    input  logic              axis_rst_n_i,
    input  fir_pkg::fir_cfg_t cfg_i,
    input  logic              ap_start_i,
    output logic              busy_o,
    output logic              run_done_o,
    input  logic              ss_tvalid_i,
    output logic              ss_tready_o,
    output logic              ring_clear_o,
    output logic              push_o,
    output fir_pkg::tap_idx_t tap_idx_o,
    output fir_pkg::mac_op_t  mac_op_o,
    input  logic              result_taken_i
);

    fir_pkg::ctrl_state_e state_q;
    fir_pkg::tap_idx_t    tap_idx_q;
    fir_pkg::len_t        cnt_q;      // samples accepted this run
    logic                 run_done_q;
    logic                 last_tap, eos;

    assign last_tap = (tap_idx_q == fir_pkg::tap_idx_t'(cfg_i.tap_num - 1'b1));
    assign eos      = (cnt_q == cfg_i.data_len);

    always_ff @(posedge axis_clk_i or negedge axis_rst_n_i) begin
        if (!axis_rst_n_i) begin
            state_q    <= fir_pkg::ST_IDLE;
            tap_idx_q  <= '0;
            cnt_q      <= '0;
            run_done_q <= 1'b0;
        end else begin
            run_done_q <= 1'b0;
            case (state_q)
                fir_pkg::ST_IDLE: begin
                    if (ap_start_i) begin
                        cnt_q <= '0;
                        if (cfg_i.data_len == '0) begin
                            run_done_q <= 1'b1;  // empty run finishes at once
                        end else begin
                            state_q <= fir_pkg::ST_WAIT_X;
                        end
                    end
                end
                fir_pkg::ST_WAIT_X: begin
                    if (ss_tvalid_i) begin
                        cnt_q     <= cnt_q + 1'b1;
                        tap_idx_q <= '0;
                        state_q   <= fir_pkg::ST_MAC;
                    end
                end
                fir_pkg::ST_MAC: begin
                    if (last_tap) begin
                        tap_idx_q <= '0;
                        state_q   <= fir_pkg::ST_OUT;
                    end else begin
                        tap_idx_q <= tap_idx_q + 1'b1;
                    end
                end
                fir_pkg::ST_OUT: begin
                    if (result_taken_i) begin
                        if (eos) begin
                            run_done_q <= 1'b1;
                            state_q    <= fir_pkg::ST_IDLE;
                        end else begin
                            state_q <= fir_pkg::ST_WAIT_X;
                        end
                    end
                end
                default: state_q <= fir_pkg::ST_IDLE;
            endcase
        end
    end

    assign busy_o       = (state_q != fir_pkg::ST_IDLE);
    assign run_done_o   = run_done_q;
    assign ss_tready_o  = (state_q == fir_pkg::ST_WAIT_X);
    assign push_o       = ss_tready_o && ss_tvalid_i;
    assign ring_clear_o = (state_q == fir_pkg::ST_IDLE) && ap_start_i;
    assign tap_idx_o    = tap_idx_q;

    assign mac_op_o.en    = (state_q == fir_pkg::ST_MAC);
    assign mac_op_o.first = (tap_idx_q == '0);
    assign mac_op_o.last  = last_tap;
    assign mac_op_o.eos   = eos;

endmodule

`default_nettype wire

// ==== engine/fir_sample_ring.sv ====
`timescale 1ns/1ps
`default_nettype none

module fir_sample_ring (
    input  logic              axis_clk_i,
    input  logic              axis_rst_n_i,
    input  logic              clear_i,
    input  logic              push_i,
    input  fir_pkg::sample_t  push_data_i,
    input  fir_pkg::tap_idx_t rd_idx_i,
    output fir_pkg::sample_t  rd_data_o
);

    fir_pkg::sample_t             slot_q [fir_pkg::MAX_TAPS];
    logic [fir_pkg::MAX_TAPS-1:0] vld_q;  // slot holds a sample of this run

    always_ff @(posedge axis_clk_i or negedge axis_rst_n_i) begin
        if (!axis_rst_n_i) begin
            vld_q <= '0;
        end else if (clear_i) begin
            vld_q <= '0;
        end else if (push_i) begin
            vld_q <= {vld_q[fir_pkg::MAX_TAPS-2:0], 1'b1};
        end
    end

    always_ff @(posedge axis_clk_i) begin
        if (push_i) begin
            slot_q[0] <= push_data_i;  // newest in slot 0
            for (int k = 1; k < fir_pkg::MAX_TAPS; k++) begin
                slot_q[k] <= slot_q[k-1];
            end
        end
    end

    // older than the run reads as zero
    assign rd_data_o = (rd_idx_i < fir_pkg::MAX_TAPS && vld_q[rd_idx_i]) ?
                       slot_q[rd_idx_i] : '0;

endmodule

`default_nettype wire

// ==== engine/fir_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module fir_mac (
    input  logic             axis_clk_i,
    input  logic             axis_rst_n_i,
    input  fir_pkg::mac_op_t op_i,
    input  fir_pkg::coef_t   coef_i,
    input  fir_pkg::sample_t sample_i,
    output logic             sm_tvalid_o,
    input  logic             sm_tready_i,
    output fir_pkg::sample_t sm_tdata_o,
    output logic             sm_tlast_o,
    output logic             result_taken_o
);

    fir_pkg::mac_op_t prod_op_q;  // op travelling with the product
    fir_pkg::acc_t    prod_q;
    fir_pkg::acc_t    acc_q;
    fir_pkg::acc_t    acc_next;
    logic             acc_last_q, acc_eos_q;  // acc_q holds a finished sum
    logic             tvalid_q, tlast_q;
    fir_pkg::sample_t tdata_q;

    assign acc_next = prod_op_q.first ? prod_q : acc_q + prod_q;

    always_ff @(posedge axis_clk_i or negedge axis_rst_n_i) begin
        if (!axis_rst_n_i) begin
            prod_op_q  <= '0;
            prod_q     <= '0;
            acc_q      <= '0;
            acc_last_q <= 1'b0;
            acc_eos_q  <= 1'b0;
            tvalid_q   <= 1'b0;
            tlast_q    <= 1'b0;
            tdata_q    <= '0;
        end else begin
            prod_op_q <= op_i;
            if (op_i.en) begin
                prod_q <= fir_pkg::acc_t'(coef_i) * fir_pkg::acc_t'(sample_i);
            end
            if (prod_op_q.en) begin
                acc_q <= acc_next;  // restart on first tap
            end
            acc_last_q <= prod_op_q.en && prod_op_q.last;
            acc_eos_q  <= prod_op_q.eos;
            if (acc_last_q) begin
                tvalid_q <= 1'b1;
                tdata_q  <= fir_pkg::sample_t'(acc_q[fir_pkg::DATA_W-1:0]);
                tlast_q  <= acc_eos_q;
            end else if (sm_tready_i) begin
                tvalid_q <= 1'b0;  // result accepted
            end
        end
    end

    assign sm_tvalid_o    = tvalid_q;
    assign sm_tdata_o     = tdata_q;
    assign sm_tlast_o     = tlast_q;
    assign result_taken_o = tvalid_q && sm_tready_i;

endmodule

`default_nettype wire

// ==== logic/fir_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fir_top (
    input  logic                         axis_clk_i,
    input  logic                         axis_rst_n_i,
    input  logic                         s_awvalid_i,
    output logic                         s_awready_o,
    input  fir_pkg::axil_addr_t          s_awaddr_i,
    input  logic                         s_wvalid_i,
    output logic                         s_wready_o,
    input  logic [fir_pkg::DATA_W-1:0]   s_wdata_i,
    output logic                         s_bvalid_o,
    input  logic                         s_bready_i,
    output logic [1:0]                   s_bresp_o,
    input  logic                         s_arvalid_i,
    output logic                         s_arready_o,
    input  fir_pkg::axil_addr_t          s_araddr_i,
    output logic                         s_rvalid_o,
    input  logic                         s_rready_i,
    output logic [fir_pkg::DATA_W-1:0]   s_rdata_o,
    output logic [1:0]                   s_rresp_o,
    input  logic                         ss_tvalid_i,
    output logic                         ss_tready_o,
    input  fir_pkg::sample_t             ss_tdata_i,
    output logic                         sm_tvalid_o,
    input  logic                         sm_tready_i,
    output fir_pkg::sample_t             sm_tdata_o,
    output logic                         sm_tlast_o
);

    fir_pkg::fir_cfg_t cfg;
    logic              ap_start, busy, run_done;
    fir_pkg::tap_wr_t  tap_wr;
    fir_pkg::tap_idx_t tap_rd_idx, tap_idx;
    fir_pkg::coef_t    tap_rd_data, coef;
    fir_pkg::sample_t  sample;
    fir_pkg::mac_op_t  mac_op;
    logic              ring_clear, push, result_taken;

    fir_axil_slave u_axil (
        .axis_clk_i    (axis_clk_i),
        .axis_rst_n_i  (axis_rst_n_i),
        .s_awvalid_i   (s_awvalid_i),
        .s_awready_o   (s_awready_o),
        .s_awaddr_i    (s_awaddr_i),
        .s_wvalid_i    (s_wvalid_i),
        .s_wready_o    (s_wready_o),
        .s_wdata_i     (s_wdata_i),
        .s_bvalid_o    (s_bvalid_o),
        .s_bready_i    (s_bready_i),
        .s_bresp_o     (s_bresp_o),
        .s_arvalid_i   (s_arvalid_i),
        .s_arready_o   (s_arready_o),
        .s_araddr_i    (s_araddr_i),
        .s_rvalid_o    (s_rvalid_o),
        .s_rready_i    (s_rready_i),
        .s_rdata_o     (s_rdata_o),
        .s_rresp_o     (s_rresp_o),
        .cfg_o         (cfg),
        .ap_start_o    (ap_start),
        .busy_i        (busy),
        .run_done_i    (run_done),
        .tap_wr_o      (tap_wr),
        .tap_rd_idx_o  (tap_rd_idx),
        .tap_rd_data_i (tap_rd_data)
    );

    fir_tap_ram u_ram (
        .axis_clk_i   (axis_clk_i),
        .axis_rst_n_i (axis_rst_n_i),
        .wr_i         (tap_wr),
        .rd_a_idx_i   (tap_rd_idx),
        .rd_b_idx_i   (tap_idx),
        .rd_a_data_o  (tap_rd_data),
        .rd_b_data_o  (coef)
    );

    fir_ctrl u_ctrl (
        .axis_clk_i     (axis_clk_i),
        .axis_rst_n_i   (axis_rst_n_i),
        .cfg_i          (cfg),
        .ap_start_i     (ap_start),
        .busy_o         (busy),
        .run_done_o     (run_done),
        .ss_tvalid_i    (ss_tvalid_i),
        .ss_tready_o    (ss_tready_o),
        .ring_clear_o   (ring_clear),
        .push_o         (push),
        .tap_idx_o      (tap_idx),
        .mac_op_o       (mac_op),
        .result_taken_i (result_taken)
    );

    fir_sample_ring u_ring (
        .axis_clk_i   (axis_clk_i),
        .axis_rst_n_i (axis_rst_n_i),
        .clear_i      (ring_clear),
        .push_i       (push),
        .push_data_i  (ss_tdata_i),
        .rd_idx_i     (tap_idx),
        .rd_data_o    (sample)
    );

    fir_mac u_mac (
        .axis_clk_i     (axis_clk_i),
        .axis_rst_n_i   (axis_rst_n_i),
        .op_i           (mac_op),
        .coef_i         (coef),
        .sample_i       (sample),
        .sm_tvalid_o    (sm_tvalid_o),
        .sm_tready_i    (sm_tready_i),
        .sm_tdata_o     (sm_tdata_o),
        .sm_tlast_o     (sm_tlast_o),
        .result_taken_o (result_taken)
    );

endmodule

`default_nettype wire

// ==== tb/fir_tb_tasks.svh ====
`ifndef FIR_TB_TASKS_SVH
`define FIR_TB_TASKS_SVH

task automatic next_cycle();
    @(posedge axis_clk);
    #1;  // drive point
endtask

task automatic check_word(input string name, input fir_pkg::sample_t exp_v,
                          input fir_pkg::sample_t act_v);
    checks++;
    if (act_v !== exp_v) begin
        errors++;
        $display("ERR %s expected %h got %h", name, exp_v, act_v);
    end
endtask

task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    checks++;
    if (act_v !== exp_v) begin
        errors++;
        $display("ERR %s expected %h got %h", name, exp_v, act_v);
    end
endtask

task automatic check_reg(input string name, input logic [fir_pkg::DATA_W-1:0] exp_v,
                         input logic [fir_pkg::DATA_W-1:0] act_v);
    checks++;
    if (act_v !== exp_v) begin
        errors++;
        $display("ERR %s expected %h got %h", name, exp_v, act_v);
    end
endtask

task automatic check_resp(input string name, input logic [1:0] exp_v, input logic [1:0] act_v);
    checks++;
    if (act_v !== exp_v) begin
        errors++;
        $display("ERR %s expected %h got %h", name, exp_v, act_v);
    end
endtask

task automatic check_latency(input int exp_v, input int act_v);
    checks++;
    if (act_v != exp_v) begin
        errors++;
        $display("result came %0d cycles after its sample instead of %0d", act_v, exp_v);
    end
endtask

function automatic int clamp_taps(input int t);
    if (t < 1) begin
        return 1;
    end
    return (t > fir_pkg::MAX_TAPS) ? fir_pkg::MAX_TAPS : t;
endfunction

// y[n] = sum h[k] * x[n-k], samples before the run are zero
task automatic compute_expected(input int r);
    longint acc;
    int     taps;
    taps = clamp_taps(taps_tab[r]);
    for (int n = 0; n < len_tab[r]; n++) begin
        acc = 0;
        for (int k = 0; k < taps; k++) begin
            if (n - k >= 0) begin
                acc += longint'(coef_tab[r][k]) * longint'(x_tab[r][n - k]);
            end
        end
        exp_tab[r][n] = fir_pkg::sample_t'(acc[31:0]);
    end
endtask

task automatic reg_write(input fir_pkg::axil_addr_t addr, input logic [fir_pkg::DATA_W-1:0] data);
    s_awaddr  = addr;
    s_wdata   = data;
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    s_bready  = 1'b1;
    while (!s_awready) begin
        next_cycle();
    end
    check_flag("s_wready", 1'b1, s_wready);  // raised with awready
    next_cycle();  // aw and w taken here
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    while (!s_bvalid) begin
        next_cycle();
    end
    check_resp("s_bresp", 2'b00, s_bresp);
    next_cycle();
    s_bready = 1'b0;
endtask

task automatic reg_read(input fir_pkg::axil_addr_t addr,
                        output logic [fir_pkg::DATA_W-1:0] data);
    s_araddr  = addr;
    s_arvalid = 1'b1;
    s_rready  = 1'b1;
    while (!s_arready) begin
        next_cycle();
    end
    next_cycle();
    s_arvalid = 1'b0;
    while (!s_rvalid) begin
        next_cycle();
    end
    data = s_rdata;
    check_resp("s_rresp", 2'b00, s_rresp);
    next_cycle();
    s_rready = 1'b0;
endtask

// one sample in, one result out; bp adds input gaps and output stalls
task automatic stream_sample(input fir_pkg::sample_t x, input logic bp, input int lat_exp,
                             input fir_pkg::sample_t exp_data, input logic exp_last);
    int   gap;
    int   lat;
    logic taken;
    gap = bp ? int'($urandom % 3) : 0;
    repeat (gap) begin
        next_cycle();
    end
    ss_tdata  = x;
    ss_tvalid = 1'b1;
    while (!ss_tready) begin
        next_cycle();
    end
    next_cycle();  // sample accepted at this edge
    ss_tvalid = 1'b0;
    lat = 0;
    while (!sm_tvalid) begin
        next_cycle();
        lat++;
    end
    if (!bp) begin
        check_latency(lat_exp, lat);
    end
    taken = 1'b0;
    while (!taken) begin
        sm_tready = bp ? (($urandom % 2) == 0) : 1'b1;
        check_flag("sm_tvalid", 1'b1, sm_tvalid);  // held under stall
        check_word("sm_tdata", exp_data, sm_tdata);
        check_flag("sm_tlast", exp_last, sm_tlast);
        check_flag("ss_tready", 1'b0, ss_tready);
        taken = sm_tready;
        next_cycle();
    end
    sm_tready = 1'b0;
    check_flag("sm_tvalid", 1'b0, sm_tvalid);  // no repeat
endtask

`endif

// ==== tb/fir_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fir_tb;

    localparam int ROWS    = 5;
    localparam int MAX_LEN = 16;

    logic                       axis_clk;
    logic                       axis_rst_n;
    logic                       s_awvalid, s_awready, s_wvalid, s_wready;
    logic                       s_bvalid, s_bready, s_arvalid, s_arready;
    logic                       s_rvalid, s_rready;
    fir_pkg::axil_addr_t        s_awaddr, s_araddr;
    logic [fir_pkg::DATA_W-1:0] s_wdata, s_rdata;
    logic [1:0]                 s_bresp, s_rresp;
    logic                       ss_tvalid, ss_tready;
    fir_pkg::sample_t           ss_tdata;
    logic                       sm_tvalid, sm_tready, sm_tlast;
    fir_pkg::sample_t           sm_tdata;

    // test table, one row per run
    string            kind_tab [ROWS];
    int               taps_tab [ROWS];  // as written, before clamping
    int               len_tab  [ROWS];
    logic             bp_tab   [ROWS];
    fir_pkg::coef_t   coef_tab [ROWS][fir_pkg::MAX_TAPS];
    fir_pkg::sample_t x_tab    [ROWS][MAX_LEN];
    fir_pkg::sample_t exp_tab  [ROWS][MAX_LEN];

    int errors    = 0;
    int checks    = 0;
    int failed    = 0;
    int cycle_cnt = 0;
    int limit     = 0;

    `include "fir_tb_tasks.svh"

    fir_top uut (
        .axis_clk_i   (axis_clk),
        .axis_rst_n_i (axis_rst_n),
        .s_awvalid_i  (s_awvalid),
        .s_awready_o  (s_awready),
        .s_awaddr_i   (s_awaddr),
        .s_wvalid_i   (s_wvalid),
        .s_wready_o   (s_wready),
        .s_wdata_i    (s_wdata),
        .s_bvalid_o   (s_bvalid),
        .s_bready_i   (s_bready),
        .s_bresp_o    (s_bresp),
        .s_arvalid_i  (s_arvalid),
        .s_arready_o  (s_arready),
        .s_araddr_i   (s_araddr),
        .s_rvalid_o   (s_rvalid),
        .s_rready_i   (s_rready),
        .s_rdata_o    (s_rdata),
        .s_rresp_o    (s_rresp),
        .ss_tvalid_i  (ss_tvalid),
        .ss_tready_o  (ss_tready),
        .ss_tdata_i   (ss_tdata),
        .sm_tvalid_o  (sm_tvalid),
        .sm_tready_i  (sm_tready),
        .sm_tdata_o   (sm_tdata),
        .sm_tlast_o   (sm_tlast)
    );

    always #2 axis_clk = ~axis_clk;

    always @(posedge axis_clk) begin  // watchdog
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= limit) begin
            $display("timeout: run did not finish");
            $display("Regression failed");
            $finish;
        end
    end

    task automatic set_row(input int r, input string kind, input int taps, input int len,
                           input logic bp);
        kind_tab[r] = kind;
        taps_tab[r] = taps;
        len_tab[r]  = len;
        bp_tab[r]   = bp;
    endtask

    task automatic fill_table();
        set_row(0, "impulse",   11, 14, 1'b0);
        set_row(1, "random",     5, 16, 1'b0);
        set_row(2, "backpress", 20, 12, 1'b1);  // clamps to 11 taps
        set_row(3, "one_tap",    0,  6, 1'b1);  // clamps to 1 tap
        set_row(4, "empty",      3,  0, 1'b0);
        for (int r = 0; r < ROWS; r++) begin
            for (int k = 0; k < fir_pkg::MAX_TAPS; k++) begin
                coef_tab[r][k] = (r == 0) ? fir_pkg::coef_t'(k + 1) : fir_pkg::coef_t'($urandom);
            end
            for (int n = 0; n < MAX_LEN; n++) begin
                if (r == 0) begin
                    x_tab[r][n] = (n == 0) ? 1 : ((n == 6) ? -3 : 0);
                end else begin
                    x_tab[r][n] = fir_pkg::sample_t'($urandom);
                end
            end
            compute_expected(r);
        end
    endtask

    function automatic int cycle_limit();
        int total;
        total = 10 + 8 * 9 + 200;  // reset, register checks, margin
        for (int r = 0; r < ROWS; r++) begin
            total += len_tab[r] * (fir_pkg::MAX_TAPS + 4) + 8 * 32;
        end
        return total;
    endfunction

    task automatic reset_checks();
        logic [fir_pkg::DATA_W-1:0] rd;
        int                         errs_before;
        errs_before = errors;
        reg_read(fir_pkg::ADDR_AP_CTRL, rd);
        check_flag("ap_idle", 1'b1, rd[fir_pkg::AP_IDLE_BIT]);
        check_flag("ap_done", 1'b0, rd[fir_pkg::AP_DONE_BIT]);
        reg_write(fir_pkg::ADDR_DATA_LEN, 32'd7);
        reg_read(fir_pkg::ADDR_DATA_LEN, rd);
        check_reg("data_len", 32'd7, rd);
        reg_write(fir_pkg::ADDR_TAP_NUM, 32'd20);
        reg_read(fir_pkg::ADDR_TAP_NUM, rd);
        check_reg("tap_num", 32'd11, rd);
        reg_write(fir_pkg::ADDR_TAP_NUM, 32'd0);
        reg_read(fir_pkg::ADDR_TAP_NUM, rd);
        check_reg("tap_num", 32'd1, rd);
        reg_read(12'h040, rd);  // hole in the map
        check_reg("unmapped", 32'd0, rd);
        if (errors != errs_before) begin
            failed++;
        end
        $display("test 0 registers %s", (errors == errs_before) ? "ok" : "FAILED");
    endtask

    task automatic run_row(input int r);
        logic [fir_pkg::DATA_W-1:0] rd;
        fir_pkg::axil_addr_t        addr;
        int                         taps;
        int                         errs_before;
        errs_before = errors;
        taps = clamp_taps(taps_tab[r]);
        reg_write(fir_pkg::ADDR_DATA_LEN, len_tab[r]);
        reg_write(fir_pkg::ADDR_TAP_NUM, taps_tab[r]);
        for (int k = 0; k < fir_pkg::MAX_TAPS; k++) begin
            addr = fir_pkg::ADDR_TAP_BASE + fir_pkg::axil_addr_t'(4 * k);
            reg_write(addr, coef_tab[r][k]);
        end
        reg_read(fir_pkg::ADDR_DATA_LEN, rd);
        check_reg("data_len", len_tab[r], rd);
        reg_read(fir_pkg::ADDR_TAP_NUM, rd);
        check_reg("tap_num", taps, rd);
        for (int k = 0; k < fir_pkg::MAX_TAPS; k++) begin
            addr = fir_pkg::ADDR_TAP_BASE + fir_pkg::axil_addr_t'(4 * k);
            reg_read(addr, rd);
            check_reg("tap", coef_tab[r][k], rd);
        end
        reg_write(fir_pkg::ADDR_AP_CTRL, 32'd1);
        if (len_tab[r] > 0) begin
            reg_read(fir_pkg::ADDR_TAP_BASE, rd);
            check_reg("tap_busy", 32'hFFFF_FFFF, rd);
            reg_write(fir_pkg::ADDR_TAP_BASE, ~coef_tab[r][0]);  // must be dropped
        end
        for (int n = 0; n < len_tab[r]; n++) begin
            stream_sample(x_tab[r][n], bp_tab[r], taps + 2, exp_tab[r][n],
                          n == len_tab[r] - 1);
        end
        rd = '0;
        while (!rd[fir_pkg::AP_DONE_BIT]) begin
            reg_read(fir_pkg::ADDR_AP_CTRL, rd);
        end
        check_flag("ap_idle", 1'b1, rd[fir_pkg::AP_IDLE_BIT]);
        if (len_tab[r] > 0) begin
            reg_read(fir_pkg::ADDR_TAP_BASE, rd);
            check_reg("tap", coef_tab[r][0], rd);
        end
        if (errors != errs_before) begin
            failed++;
        end
        $display("test %0d %s %s", r + 1, kind_tab[r], (errors == errs_before) ? "ok" : "FAILED");
    endtask

    initial begin
        void'($urandom(61132));
        axis_clk   = 1'b0;
        axis_rst_n = 1'b0;
        s_awvalid  = 1'b0;
        s_awaddr   = '0;
        s_wvalid   = 1'b0;
        s_wdata    = '0;
        s_bready   = 1'b0;
        s_arvalid  = 1'b0;
        s_araddr   = '0;
        s_rready   = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        sm_tready  = 1'b0;
        fill_table();
        limit = cycle_limit();
        repeat (10) begin
            @(posedge axis_clk);
        end
        #1;
        axis_rst_n = 1'b1;
        next_cycle();
        reset_checks();
        for (int r = 0; r < ROWS; r++) begin
            run_row(r);
        end
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 ROWS + 1, failed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fir_top.f ====
common/fir_pkg.sv
axil/fir_axil_slave.sv
logic/fir_tap_ram.sv
logic/fir_ctrl.sv
engine/fir_sample_ring.sv
engine/fir_mac.sv
logic/fir_top.sv
+incdir+tb
tb/fir_tb.sv

// ==== Bender.yml ====
package:
  name: fir_top

sources:
  - files:
      - common/fir_pkg.sv
      - axil/fir_axil_slave.sv
      - logic/fir_tap_ram.sv
      - logic/fir_ctrl.sv
      - engine/fir_sample_ring.sv
      - engine/fir_mac.sv
      - logic/fir_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/fir_tb.sv
